/* dist_net.f */
+incdir+.
dist_net_noc_pkg.sv
dist_net_pe_pkg.sv
dist_net_wgt_chain.sv
dist_net_act_tree.sv
dist_net_pe_row.sv
dist_net_top.sv
tb_dist_net.sv

/* dist_net_act_tree.sv */
`include "dist_net_cfg.svh"

// registered activation tree, root -> two branches -> one leaf per node
// unicast and multicast share the same path, only the mask decode differs
module dist_net_act_tree (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic                                           i_en,     // 0 flushes all levels
    input  dist_net_noc_pkg::dn_act_flit_t                 i_act,
    output dist_net_noc_pkg::dn_deliv_t [`DN_NUM_NODE-1:0] o_deliv
);
    import dist_net_noc_pkg::*;

    localparam int NN = `DN_NUM_NODE;
    localparam int HN = NN / 2;   // nodes under each branch

    typedef struct packed {
        logic          valid;
        logic [NN-1:0] mask;   // full row
        dn_data_t      data;
    } root_t;

    typedef struct packed {
        logic          valid;
        logic [HN-1:0] mask;   // own half only
        dn_data_t      data;
    } branch_t;

    logic [NN-1:0]         dec_mask;   // decoded destination
    root_t                 root_q;
    branch_t   [1:0]       br_q;
    dn_deliv_t [NN-1:0]    leaf_q;

    // union decode, mask view or one-hot from the id view
    always_comb
    begin
        dec_mask = '0;
        if (i_act.mcast)
            dec_mask = i_act.dest.mask;
        else
            dec_mask[i_act.dest.uni.id] = 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            root_q <= '0;
        end
        else if (!i_en)
        begin
            root_q <= '0;
        end
        else
        begin
            root_q.valid <= i_act.valid;
            root_q.mask  <= dec_mask;
            root_q.data  <= i_act.data;
        end
    end

    genvar b, n;
    generate
        for (b = 0; b < 2; b++)
        begin : g_branch
            always_ff @(posedge clk or negedge rst_n)
            begin
                if (!rst_n)
                begin
                    br_q[b] <= '0;
                end
                else if (!i_en)
                begin
                    br_q[b] <= '0;
                end
                else
                begin
                    // branch only wakes if some node below it is selected
                    br_q[b].valid <= root_q.valid & (|root_q.mask[b*HN +: HN]);
                    br_q[b].mask  <= root_q.mask[b*HN +: HN];
                    br_q[b].data  <= root_q.data;
                end
            end
        end

        for (n = 0; n < NN; n++)
        begin : g_leaf
            always_ff @(posedge clk or negedge rst_n)
            begin
                if (!rst_n)
                begin
                    leaf_q[n] <= '0;
                end
                else if (!i_en)
                begin
                    leaf_q[n] <= '0;
                end
                else
                begin
                    leaf_q[n].valid <= br_q[n/HN].valid & br_q[n/HN].mask[n%HN];
                    leaf_q[n].data  <= br_q[n/HN].data;
                end
            end
        end
    endgenerate

    assign o_deliv = leaf_q;   // three edges after entry

    // unicast id must not alias into the pad bits
    a_uni_pad: assert property (@(posedge clk) disable iff (!rst_n)
        (i_act.valid && !i_act.mcast) |-> (i_act.dest.uni.pad == '0));

    // an empty multicast would vanish silently
    a_mcast_nz: assert property (@(posedge clk) disable iff (!rst_n)
        (i_act.valid && i_act.mcast) |-> (|i_act.dest.mask));

endmodule

/* dist_net_cfg.svh */
`ifndef DIST_NET_CFG_SVH
`define DIST_NET_CFG_SVH

// row size, power of two and at least 2
// the activation tree splits the row in two halves
`define DN_NUM_NODE 4

// weight and activation word width
`define DN_DATA_W 16

// accumulator width
// holds the 2*DATA_W product plus headroom for the sum
// overflow wraps
`define DN_ACC_W 40

// node id width, derived from the row size
`define DN_ID_W $clog2(`DN_NUM_NODE)

`endif

/* dist_net_noc_pkg.sv */
`include "dist_net_cfg.svh"

package dist_net_noc_pkg;

    typedef logic [`DN_ID_W-1:0]   dn_node_id_t;   // node index
    typedef logic [`DN_DATA_W-1:0] dn_data_t;      // operand word, read as signed by the row

    // unicast view of the destination word
    // id sits in the low bits, everything above must be zero
    typedef struct packed {
        logic [`DN_NUM_NODE-`DN_ID_W-1:0] pad;
        dn_node_id_t                      id;
    } dn_uni_t;

    // one destination word, two readings
    typedef union packed {
        logic [`DN_NUM_NODE-1:0] mask;   // bit n selects node n
        dn_uni_t                 uni;    // single target
    } dn_dest_u;

    // weight chain flit, dest travels with data
    typedef struct packed {
        logic        valid;
        dn_node_id_t dest;
        dn_data_t    data;
    } dn_wgt_flit_t;

    // activation tree flit
    typedef struct packed {
        logic     valid;
        logic     mcast;   // 1 = mask view
        dn_dest_u dest;
        dn_data_t data;
    } dn_act_flit_t;

    // per node delivery strobe, both networks
    typedef struct packed {
        logic     valid;
        dn_data_t data;
    } dn_deliv_t;

endpackage

/* dist_net_pe_pkg.sv */
`include "dist_net_cfg.svh"

package dist_net_pe_pkg;

    // running sum per node, signed
    // wraps on overflow
    typedef logic signed [`DN_ACC_W-1:0] dn_acc_t;

    // one result strobe per node
    // sum is only meaningful with valid high
    typedef struct packed {
        logic    valid;   // one cycle per delivered activation
        dn_acc_t sum;     // accumulator after the update
    } dn_result_t;

endpackage

/* dist_net_pe_row.sv */
`include "dist_net_cfg.svh"

// processing row with one weight register and one accumulator per node
module dist_net_pe_row (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            i_clear,   // zero all sums
    input  dist_net_noc_pkg::dn_deliv_t  [`DN_NUM_NODE-1:0] i_wgt,     // from weight chain
    input  dist_net_noc_pkg::dn_deliv_t  [`DN_NUM_NODE-1:0] i_act,     // from activation tree
    output dist_net_pe_pkg::dn_result_t  [`DN_NUM_NODE-1:0] o_result
);
    import dist_net_noc_pkg::*;
    import dist_net_pe_pkg::*;

    localparam int NN = `DN_NUM_NODE;
    localparam int DW = `DN_DATA_W;

    logic [NN-1:0] act_vld;   // gathered for the usage check

    genvar g;
    generate
        for (g = 0; g < NN; g++)
        begin : g_node
            dn_data_t                wgt_q;       // last delivered weight
            dn_acc_t                 acc_q;
            logic                    res_vld_q;
            logic signed [2*DW-1:0]  prod;

            assign act_vld[g] = i_act[g].valid;

            // product uses the weight held before this edge
            assign prod = (2*DW)'($signed(i_act[g].data)) * (2*DW)'($signed(wgt_q));

            always_ff @(posedge clk or negedge rst_n)
            begin
                if (!rst_n)
                    wgt_q <= '0;
                else if (i_wgt[g].valid)
                    wgt_q <= i_wgt[g].data;   // takes effect next edge
            end

            always_ff @(posedge clk or negedge rst_n)
            begin
                if (!rst_n)
                begin
                    acc_q     <= '0;
                    res_vld_q <= 1'b0;
                end
                else
                begin
                    res_vld_q <= i_act[g].valid & ~i_clear;
                    if (i_clear)
                        acc_q <= '0;   // clear wins
                    else if (i_act[g].valid)
                        acc_q <= acc_q + dn_acc_t'(prod);   // sign extended product
                end
            end

            // sum is the freshly updated accumulator
            assign o_result[g].valid = res_vld_q;
            assign o_result[g].sum   = acc_q;
        end
    endgenerate

    // clear must not land on a live activation
    a_clear_act: assert property (@(posedge clk) disable iff (!rst_n)
        !(i_clear && (|act_vld)));

endmodule

/* dist_net_top.sv */
`include "dist_net_cfg.svh"

// operand distribution front end, weight chain and activation tree
// feeding one processing row
module dist_net_top (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic                                           i_en,      // network enable level
    input  dist_net_noc_pkg::dn_wgt_flit_t                 i_wgt,
    input  dist_net_noc_pkg::dn_act_flit_t                 i_act,
    input  logic                                           i_clear,   // one cycle pulse
    output dist_net_pe_pkg::dn_result_t [`DN_NUM_NODE-1:0] o_result
);
    import dist_net_noc_pkg::*;

    dn_deliv_t [`DN_NUM_NODE-1:0] w_deliv;   // weight per node
    dn_deliv_t [`DN_NUM_NODE-1:0] a_deliv;   // activation per node

    dist_net_wgt_chain u_wgt_chain (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_en    (i_en),
        .i_wgt   (i_wgt),
        .o_deliv (w_deliv)
    );

    dist_net_act_tree u_act_tree (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_en    (i_en),
        .i_act   (i_act),
        .o_deliv (a_deliv)
    );

    // row ignores i_en, only deliveries move it
    dist_net_pe_row u_pe_row (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_clear  (i_clear),
        .i_wgt    (w_deliv),
        .i_act    (a_deliv),
        .o_result (o_result)
    );

endmodule

/* dist_net_wgt_chain.sv */
`include "dist_net_cfg.svh"

// store and forward weight chain with one stage per node
// a flit walks down the chain until its dest matches the stage index
module dist_net_wgt_chain (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic                                           i_en,     // 0 flushes all stages
    input  dist_net_noc_pkg::dn_wgt_flit_t                 i_wgt,    // at most one per cycle
    output dist_net_noc_pkg::dn_deliv_t [`DN_NUM_NODE-1:0] o_deliv
);
    import dist_net_noc_pkg::*;

    localparam int NN = `DN_NUM_NODE;

    dn_wgt_flit_t [NN-1:0] stg_q;   // flit held by each stage
    dn_deliv_t    [NN-1:0] dlv_q;   // registered delivery per node
    logic         [NN-1:0] hit;     // stage flit is for this node

    genvar g;
    generate
        for (g = 0; g < NN; g++)
        begin : g_stage
            dn_wgt_flit_t stg_d;   // what this stage loads next edge

            // stage index comes from the generate constant
            assign hit[g] = stg_q[g].valid && (stg_q[g].dest == dn_node_id_t'(g));

            if (g == 0)
            begin : g_head
                assign stg_d = i_wgt;   // chain entry
            end
            else
            begin : g_link
                // predecessor keeps a flit it delivered
                assign stg_d.valid = stg_q[g-1].valid & ~hit[g-1];
                assign stg_d.dest  = stg_q[g-1].dest;
                assign stg_d.data  = stg_q[g-1].data;
            end

            always_ff @(posedge clk or negedge rst_n)
            begin
                if (!rst_n)
                begin
                    stg_q[g] <= '0;
                end
                else if (!i_en)
                begin
                    stg_q[g] <= '0;   // drop in-flight flit
                end
                else
                begin
                    stg_q[g] <= stg_d;
                end
            end

            // delivery lags the stage by one edge
            always_ff @(posedge clk or negedge rst_n)
            begin
                if (!rst_n)
                begin
                    dlv_q[g] <= '0;
                end
                else if (!i_en)
                begin
                    dlv_q[g] <= '0;
                end
                else
                begin
                    dlv_q[g].valid <= hit[g];
                    dlv_q[g].data  <= stg_q[g].data;   // payload only counts with valid
                end
            end
        end
    endgenerate

    assign o_deliv = dlv_q;

    // ids span exactly the row, so nothing can run past the tail
    a_tail_hit: assert property (@(posedge clk) disable iff (!rst_n)
        stg_q[NN-1].valid |-> (stg_q[NN-1].dest == dn_node_id_t'(NN-1)));

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the dist_net testbench with Verilator
# verdict comes from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing --assert -j 0 --top-module tb_dist_net -f dist_net.f \
    > build.log 2>&1 && ./obj_dir/Vtb_dist_net > sim.log 2>&1

grep -q "Some tests failed" sim.log && { echo "simulation FAILED, see sim.log"; exit 1; }
grep -q "All tests passed" sim.log || { echo "no pass line, see build.log and sim.log"; exit 1; }
echo "simulation PASSED"
exit 0

/* tb_dist_net.sv */
`include "dist_net_cfg.svh"

// directed testbench for dist_net_top with an edge-indexed reference model
module tb_dist_net;
    timeunit 1ns;
    timeprecision 1ps;

    import dist_net_noc_pkg::*;
    import dist_net_pe_pkg::*;

    localparam int NN = `DN_NUM_NODE;

    // one expected result strobe keyed by the edge it shows after
    typedef struct packed {
        int                     edge_no;
        logic [NN-1:0]          mask;   // nodes that must report
        dn_acc_t [NN-1:0]       sum;
    } exp_t;

    logic                  clk;
    logic                  rst_n;
    logic                  i_en;
    logic                  i_clear;
    dn_wgt_flit_t          i_wgt;
    dn_act_flit_t          i_act;
    dn_result_t [NN-1:0]   o_result;

    int          edge_cnt = 0;   // rising edges seen so far
    logic [31:0] lfsr     = 32'h8af4;
    exp_t        exp_q [$];      // pending strobes, in edge order

    // reference state per node
    dn_data_t wgt_old  [NN];
    dn_data_t wgt_new  [NN];
    int       wgt_edge [NN];     // first edge the new weight is held
    dn_acc_t  ref_sum  [NN];

    dist_net_top u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_en     (i_en),
        .i_wgt    (i_wgt),
        .i_act    (i_act),
        .i_clear  (i_clear),
        .o_result (o_result)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
        edge_cnt <= edge_cnt + 1;

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    endtask

    // taps of x^32 + x^22 + x^2 + x + 1
    // one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        int          i;
        r = '0;
        for (i = 0; i < n; i++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // signed product widened then cut to accumulator size
    function automatic dn_acc_t product_of(input dn_data_t a, input dn_data_t w);
        longint pa;
        longint pw;
        pa = longint'($signed(a));
        pw = longint'($signed(w));
        return dn_acc_t'(pa * pw);
    endfunction

    function automatic dn_data_t weight_seen_at(input int n, input int e);
        return (e >= wgt_edge[n]) ? wgt_new[n] : wgt_old[n];
    endfunction

    function automatic dn_dest_u uni_dest(input int k);
        dn_dest_u d;
        d        = '0;
        d.uni.id = dn_node_id_t'(k);
        return d;
    endfunction

    task automatic check_result(input dn_result_t r, input int n, input dn_acc_t exp_sum);
        if (!r.valid)
            stop_on_error($sformatf("MISMATCH o_result[%0d].valid exp 0x1 got 0x%h", n, r.valid));
        else if (r.sum !== exp_sum)
            stop_on_error($sformatf("MISMATCH o_result[%0d].sum exp 0x%h got 0x%h",
                                    n, exp_sum, r.sum));
    endtask

    task automatic check_valid_bits(input dn_result_t [NN-1:0] r, input logic [NN-1:0] want);
        logic [NN-1:0] got;
        int            n;
        for (n = 0; n < NN; n++)
            got[n] = r[n].valid;
        if (got !== want)
            stop_on_error($sformatf("MISMATCH o_result valid bits exp 0x%h got 0x%h", want, got));
    endtask

    task automatic check_idle(input dn_result_t [NN-1:0] r);
        check_valid_bits(r, '0);
    endtask

    // step one edge, compare outputs and idle the flit inputs
    task automatic step_and_compare();
        exp_t e;
        int   n;
        @(posedge clk);
        #5;
        if (exp_q.size() > 0 && exp_q[0].edge_no == edge_cnt)
        begin
            e = exp_q.pop_front();
            for (n = 0; n < NN; n++)
                if (e.mask[n])
                    check_result(o_result[n], n, e.sum[n]);
            check_valid_bits(o_result, e.mask);   // no unselected node may report
        end
        else
        begin
            check_idle(o_result);
        end
        i_wgt   = '0;
        i_act   = '0;
        i_clear = 1'b0;
    endtask

    task automatic wait_results();
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < 20)
        begin
            step_and_compare();
            waited++;
        end
        if (exp_q.size() > 0)
            stop_on_error("timeout: an expected result did not appear within 20 cycles");
    endtask

    // rec = 0 for flits that a flush is meant to drop
    task automatic put_wgt(input int k, input dn_data_t d, input bit rec);
        i_wgt.valid = 1'b1;
        i_wgt.dest  = dn_node_id_t'(k);
        i_wgt.data  = d;
        if (rec)
        begin
            wgt_old[k]  = weight_seen_at(k, edge_cnt + k + 2);
            wgt_new[k]  = d;
            wgt_edge[k] = edge_cnt + 1 + k + 2;   // held from entry+k+2 on
        end
    endtask

    task automatic put_act(input logic mc, input dn_dest_u dst, input dn_data_t d, input bit rec);
        exp_t e;
        int   n;
        int   a_edge;
        i_act.valid = 1'b1;
        i_act.mcast = mc;
        i_act.dest  = dst;
        i_act.data  = d;
        if (rec)
        begin
            a_edge    = edge_cnt + 1;
            e.edge_no = a_edge + 3;   // delivered at +2 and summed at +3
            e.mask    = '0;
            if (mc)
                e.mask = dst.mask;
            else
                e.mask[dst.uni.id] = 1'b1;
            for (n = 0; n < NN; n++)
            begin
                if (e.mask[n])
                    ref_sum[n] = ref_sum[n] + product_of(d, weight_seen_at(n, a_edge + 2));
                e.sum[n] = ref_sum[n];
            end
            exp_q.push_back(e);
        end
    endtask

    task automatic put_clear();
        int n;
        i_clear = 1'b1;
        for (n = 0; n < NN; n++)
            ref_sum[n] = '0;
    endtask

    task automatic check_reset_state();
        $display("reset state");
        repeat (10) step_and_compare();
    endtask

    task automatic unicast_load_and_use();
        int k;
        $display("unicast weights and activations");
        for (k = 0; k < NN; k++)
        begin
            put_wgt(k, dn_data_t'(lfsr_bits(16)), 1'b1);
            step_and_compare();
        end
        for (k = 0; k < NN; k++)
        begin
            put_act(1'b0, uni_dest(k), dn_data_t'(lfsr_bits(16)), 1'b1);
            step_and_compare();
        end
        wait_results();
    endtask

    task automatic multicast_accumulate();
        dn_dest_u    d;
        logic [31:0] r;
        int          i;
        $display("multicast accumulation");
        for (i = 0; i < 6; i++)
        begin
            r      = lfsr_bits(NN);
            d.mask = r[NN-1:0];
            if (d.mask == '0)
                d.mask[0] = 1'b1;   // empty multicast is illegal
            put_act(1'b1, d, dn_data_t'(lfsr_bits(16)), 1'b1);
            step_and_compare();
        end
        wait_results();
    endtask

    // first activation meets the new weights at their delivery edge
    task automatic weight_stream_overlap();
        dn_dest_u all;
        int       k;
        $display("back to back weight stream");
        all.mask = '1;
        for (k = NN - 1; k >= 0; k--)
        begin
            put_wgt(k, dn_data_t'(lfsr_bits(16)), 1'b1);
            if (k <= 1)
                put_act(1'b1, all, dn_data_t'(lfsr_bits(16)), 1'b1);
            step_and_compare();
        end
        put_act(1'b1, all, dn_data_t'(lfsr_bits(16)), 1'b1);
        step_and_compare();
        wait_results();
    endtask

    task automatic enable_flush();
        dn_dest_u all;
        $display("enable flush");
        all.mask = '1;
        put_wgt(NN - 1, dn_data_t'(lfsr_bits(16)), 1'b0);
        put_act(1'b1, all, dn_data_t'(lfsr_bits(16)), 1'b0);
        step_and_compare();
        step_and_compare();   // flits now mid network
        i_en = 1'b0;
        step_and_compare();
        i_en = 1'b1;
        repeat (6) step_and_compare();   // nothing may leak out
        put_act(1'b1, all, dn_data_t'(lfsr_bits(16)), 1'b1);
        step_and_compare();
        wait_results();
    endtask

    task automatic clear_then_single();
        int k;
        $display("clear");
        wait_results();
        put_clear();
        step_and_compare();
        for (k = 0; k < NN; k++)
        begin
            put_act(1'b0, uni_dest(k), dn_data_t'(lfsr_bits(16)), 1'b1);
            step_and_compare();
        end
        wait_results();
    endtask

    initial
    begin
        int n;
        rst_n   = 1'b0;
        i_en    = 1'b1;
        i_clear = 1'b0;
        i_wgt   = '0;
        i_act   = '0;
        for (n = 0; n < NN; n++)
        begin
            wgt_old[n]  = '0;
            wgt_new[n]  = '0;
            wgt_edge[n] = 0;
            ref_sum[n]  = '0;
        end
        repeat (5) @(posedge clk);
        #5;
        rst_n = 1'b1;
        check_reset_state();
        unicast_load_and_use();
        multicast_accumulate();
        weight_stream_overlap();
        enable_flush();
        clear_then_single();
        $display("All tests passed");
        $finish;
    end

endmodule
